// ==== src/lsu_config.svh ====
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// log2 of entry counts
`define LSU_LOAD_RS_DEPTH 2
`define LSU_STORE_Q_DEPTH 2
`define LSU_LOAD_RS_SIZE (1 << `LSU_LOAD_RS_DEPTH)
`define LSU_STORE_Q_SIZE (1 << `LSU_STORE_Q_DEPTH)

`define LSU_ROB_DEPTH 3
`define LSU_CDB_SIZE 2

`endif

// ==== src/rv32i_pkg.sv ====
`default_nettype none

package rv32i_pkg;

    // load funct3 encodings from the base ISA
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_t;

    // one memory word seen as byte lanes or half lanes
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } mem_word_u;

endpackage

`default_nettype wire

// ==== src/lsu_pkg.sv ====
`default_nettype none
`include "lsu_config.svh"

package lsu_pkg;

    // one load as handed over at dispatch
    typedef struct packed {
        rv32i_pkg::load_funct3_t   funct3;
        logic [31:0]               imm;
        logic [`LSU_ROB_DEPTH-1:0] target_rob;
        logic                      rs1_ready;
        logic [`LSU_ROB_DEPTH-1:0] rs1_rob;
        logic [31:0]               rs1_v;
    } load_issue_t;

    // common data bus slot, snooped and driven
    typedef struct packed {
        logic                      valid;
        logic [`LSU_ROB_DEPTH-1:0] rob;
        logic [31:0]               value;
    } cdb_result_t;

endpackage

`default_nettype wire

// ==== src/dmem_rd_if.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lsu_config.svh"

interface dmem_rd_if;
    import rv32i_pkg::*;

    logic                          rqst;
    logic [`LSU_LOAD_RS_DEPTH-1:0] rqst_idx;
    logic [31:0]                   addr;
    load_funct3_t                  funct3;
    logic                          accept;
    logic                          done;
    logic [`LSU_LOAD_RS_DEPTH-1:0] done_idx;
    logic [31:0]                   rdata;

    modport station (output rqst, rqst_idx, addr, funct3,
                     input accept, done, done_idx, rdata);
    modport engine (input rqst, rqst_idx, addr, funct3,
                    output accept, done, done_idx, rdata);
endinterface

`default_nettype wire

// ==== src/store_queue.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lsu_config.svh"

module store_queue (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          flush,
    input  logic                          alloc,
    output logic [`LSU_STORE_Q_DEPTH-1:0] alloc_tag,
    input  logic                          resolve,
    input  logic [`LSU_STORE_Q_DEPTH-1:0] resolve_tag,
    input  logic [31:0]                   resolve_addr,
    input  logic                          commit,
    output logic [`LSU_STORE_Q_DEPTH-1:0] youngest,
    output logic [`LSU_STORE_Q_DEPTH:0]   count,
    output logic [`LSU_STORE_Q_SIZE-1:0]  addr_known,
    output logic [31:0]                   addr [`LSU_STORE_Q_SIZE]
);
    localparam int N = `LSU_STORE_Q_SIZE;
    localparam int CNT_W = `LSU_STORE_Q_DEPTH + 1;

    logic [`LSU_STORE_Q_DEPTH-1:0] head;
    logic [`LSU_STORE_Q_DEPTH-1:0] tail;
    logic                          commit_ok;
    logic                          alloc_ok;

    assign commit_ok = commit && (count != '0);
    // a full queue still takes a store if the head retires this cycle
    assign alloc_ok = alloc && ((count != CNT_W'(N)) || commit_ok);

    assign alloc_tag = tail;
    assign youngest = tail - 1'b1;

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            addr_known <= '0;
        end else begin
            if (resolve) begin
                addr_known[resolve_tag] <= 1'b1;
            end
            if (commit_ok) begin
                addr_known[head] <= 1'b0;
                head <= head + 1'b1;
            end
            if (alloc_ok) begin
                addr_known[tail] <= 1'b0;
                tail <= tail + 1'b1;
            end
            count <= count + CNT_W'(alloc_ok) - CNT_W'(commit_ok);
        end
    end

    always_ff @(posedge clk) begin
        if (resolve) begin
            addr[resolve_tag] <= resolve_addr;
        end
    end

endmodule

`default_nettype wire

// ==== src/load_rs.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lsu_config.svh"

module load_rs (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          flush,
    input  logic                          issue_valid,
    input  lsu_pkg::load_issue_t          issue,
    output logic                          issue_ready,
    input  lsu_pkg::cdb_result_t          cdb [`LSU_CDB_SIZE],
    input  logic [`LSU_STORE_Q_DEPTH-1:0] sq_youngest,
    input  logic [`LSU_STORE_Q_DEPTH:0]   sq_count,
    input  logic [`LSU_STORE_Q_SIZE-1:0]  sq_addr_known,
    input  logic [31:0]                   sq_addr [`LSU_STORE_Q_SIZE],
    input  logic                          sq_commit,
    dmem_rd_if.station                    rd,
    output lsu_pkg::cdb_result_t          result
);
    import lsu_pkg::*;

    localparam int RS_N = `LSU_LOAD_RS_SIZE;
    localparam int RS_W = `LSU_LOAD_RS_DEPTH;
    localparam int SQ_N = `LSU_STORE_Q_SIZE;
    localparam int SQ_W = `LSU_STORE_Q_DEPTH;

    load_issue_t       ent [RS_N];
    logic [SQ_W-1:0]   ent_youngest [RS_N];
    logic [SQ_W:0]     ent_count [RS_N];
    logic [31:0]       ea [RS_N];
    logic [RS_N-1:0]   ent_valid;
    logic [RS_N-1:0]   ent_busy;
    logic [RS_N-1:0]   ent_solved;
    logic [RS_N-1:0]   ent_may_load;
    logic [RS_N-1:0]   solved_chk;
    logic [RS_N-1:0]   clear_chk;
    logic [RS_W-1:0]   rr_ptr;
    logic [RS_W-1:0]   free_idx;
    logic [RS_W-1:0]   sel_idx;
    logic              issue_fire;
    load_issue_t       issue_rec;

    assign issue_ready = |(~ent_valid);
    assign issue_fire = issue_valid && issue_ready;

    always_comb begin
        free_idx = '0;
        for (int i = RS_N - 1; i >= 0; i--) begin
            if (!ent_valid[i]) begin
                free_idx = RS_W'(i);
            end
        end
    end

    // catch a broadcast of rs1 landing in the issue cycle
    always_comb begin
        issue_rec = issue;
        for (int j = 0; j < `LSU_CDB_SIZE; j++) begin
            if (!issue.rs1_ready && cdb[j].valid && cdb[j].rob == issue.rs1_rob) begin
                issue_rec.rs1_ready = 1'b1;
                issue_rec.rs1_v = cdb[j].value;
            end
        end
    end

    // scan back from the recorded youngest store over the older ones
    always_comb begin
        logic [SQ_W-1:0] sq_idx;
        for (int i = 0; i < RS_N; i++) begin
            ea[i] = ent[i].rs1_v + ent[i].imm;
            solved_chk[i] = 1'b1;
            clear_chk[i] = 1'b1;
            for (int j = 0; j < SQ_N; j++) begin
                sq_idx = ent_youngest[i] - SQ_W'(j);
                if ((SQ_W + 1)'(j) < ent_count[i]) begin
                    if (!sq_addr_known[sq_idx]) begin
                        solved_chk[i] = 1'b0;
                    end
                    if (sq_addr[sq_idx][31:2] == ea[i][31:2]) begin
                        clear_chk[i] = 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            ent_valid <= '0;
            ent_busy <= '0;
            ent_solved <= '0;
            ent_may_load <= '0;
            rr_ptr <= '0;
        end else begin
            if (issue_fire) begin
                ent_valid[free_idx] <= 1'b1;
                ent_busy[free_idx] <= 1'b0;
                ent_solved[free_idx] <= 1'b0;
                ent_may_load[free_idx] <= 1'b0;
            end
            for (int i = 0; i < RS_N; i++) begin
                if (ent_valid[i] && !ent_solved[i] && solved_chk[i]) begin
                    ent_solved[i] <= 1'b1;
                end
                if (ent_valid[i] && !ent_may_load[i] && ent[i].rs1_ready &&
                    ent_solved[i] && clear_chk[i]) begin
                    ent_may_load[i] <= 1'b1;
                end
            end
            // held by the engine until its done
            if (rd.accept) begin
                ent_busy[rd.rqst_idx] <= 1'b1;
            end
            if (rd.done) begin
                ent_valid[rd.done_idx] <= 1'b0;
                ent_busy[rd.done_idx] <= 1'b0;
                ent_solved[rd.done_idx] <= 1'b0;
                ent_may_load[rd.done_idx] <= 1'b0;
                rr_ptr <= rd.done_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fire) begin
            ent[free_idx] <= issue_rec;
            ent_youngest[free_idx] <= sq_youngest;
            if (sq_commit && sq_count != '0) begin
                ent_count[free_idx] <= sq_count - 1'b1;
            end else begin
                ent_count[free_idx] <= sq_count;
            end
        end
        for (int i = 0; i < RS_N; i++) begin
            if (ent_valid[i]) begin
                for (int j = 0; j < `LSU_CDB_SIZE; j++) begin
                    if (!ent[i].rs1_ready && cdb[j].valid && cdb[j].rob == ent[i].rs1_rob) begin
                        ent[i].rs1_ready <= 1'b1;
                        ent[i].rs1_v <= cdb[j].value;
                    end
                end
                if (sq_commit && ent_count[i] != '0) begin
                    ent_count[i] <= ent_count[i] - 1'b1;
                end
            end
        end
    end

    // round robin from the slot after the last completion
    always_comb begin
        logic            found;
        logic [RS_W-1:0] idx;
        found = 1'b0;
        sel_idx = rr_ptr;
        for (int i = 0; i < RS_N; i++) begin
            idx = rr_ptr + RS_W'(i);
            if (!found && ent_valid[idx] && ent_may_load[idx] && !ent_busy[idx]) begin
                found = 1'b1;
                sel_idx = idx;
            end
        end
        rd.rqst = found;
    end

    assign rd.rqst_idx = sel_idx;
    assign rd.addr = ea[sel_idx];
    assign rd.funct3 = ent[sel_idx].funct3;

    assign result = '{valid: rd.done, rob: ent[rd.done_idx].target_rob, value: rd.rdata};

endmodule

`default_nettype wire

// ==== src/dmem_read_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lsu_config.svh"

module dmem_read_fsm (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        flush,
    dmem_rd_if.engine   rd,
    output logic        arvalid,
    output logic [31:0] araddr,
    input  logic        arready,
    input  logic        rvalid,
    input  logic [31:0] rdata,
    output logic        rready
);
    import rv32i_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_ADDR,
        S_DATA
    } state_t;

    state_t                        state;
    logic [`LSU_LOAD_RS_DEPTH-1:0] idx_q;
    logic [31:0]                   addr_q;
    load_funct3_t                  funct3_q;
    // read outlived a flush, finish on AXI but report nothing
    logic                          dropped;
    mem_word_u                     word;
    logic [7:0]                    lane_b;
    logic [15:0]                   lane_h;

    assign rd.accept = (state == S_IDLE) && rd.rqst && !flush;
    assign rd.done = (state == S_DATA) && rvalid && !dropped && !flush;
    assign rd.done_idx = idx_q;

    assign arvalid = (state == S_ADDR);
    assign araddr = {addr_q[31:2], 2'b00};
    assign rready = (state == S_DATA);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= S_IDLE;
            dropped <= 1'b0;
        end else begin
            case (state)
                S_IDLE: if (rd.accept) state <= S_ADDR;
                S_ADDR: if (arready) state <= S_DATA;
                S_DATA: if (rvalid) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
            if (rd.accept) begin
                dropped <= 1'b0;
            end else if (flush && state != S_IDLE) begin
                dropped <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd.accept) begin
            idx_q <= rd.rqst_idx;
            addr_q <= rd.addr;
            funct3_q <= rd.funct3;
        end
    end

    // lane select by low address bits, then extend
    always_comb begin
        word = rdata;
        lane_b = word.bytes[addr_q[1:0]];
        lane_h = word.halves[addr_q[1]];
        case (funct3_q)
            lb:      rd.rdata = {{24{lane_b[7]}}, lane_b};
            lbu:     rd.rdata = {24'h0, lane_b};
            lh:      rd.rdata = {{16{lane_h[15]}}, lane_h};
            lhu:     rd.rdata = {16'h0, lane_h};
            default: rd.rdata = word;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/load_unit_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lsu_config.svh"

module load_unit_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          flush,
    input  logic                          issue_valid,
    output logic                          issue_ready,
    input  logic [2:0]                    issue_funct3,
    input  logic [31:0]                   issue_imm,
    input  logic [`LSU_ROB_DEPTH-1:0]     issue_target_rob,
    input  logic                          issue_rs1_ready,
    input  logic [`LSU_ROB_DEPTH-1:0]     issue_rs1_rob,
    input  logic [31:0]                   issue_rs1_v,
    input  logic                          cdb_valid [`LSU_CDB_SIZE],
    input  logic [`LSU_ROB_DEPTH-1:0]     cdb_rob [`LSU_CDB_SIZE],
    input  logic [31:0]                   cdb_value [`LSU_CDB_SIZE],
    input  logic                          store_alloc,
    output logic [`LSU_STORE_Q_DEPTH-1:0] store_tag,
    input  logic                          store_resolve,
    input  logic [`LSU_STORE_Q_DEPTH-1:0] store_resolve_tag,
    input  logic [31:0]                   store_resolve_addr,
    input  logic                          store_commit,
    output logic                          arvalid,
    output logic [31:0]                   araddr,
    output logic [2:0]                    arprot,
    input  logic                          arready,
    input  logic                          rvalid,
    input  logic [31:0]                   rdata,
    input  logic [1:0]                    rresp,
    output logic                          rready,
    output logic                          result_valid,
    output logic [`LSU_ROB_DEPTH-1:0]     result_rob,
    output logic [31:0]                   result_value
);
    import rv32i_pkg::*;
    import lsu_pkg::*;

    load_issue_t                   issue;
    cdb_result_t                   cdb [`LSU_CDB_SIZE];
    cdb_result_t                   result;
    logic [`LSU_STORE_Q_DEPTH-1:0] sq_youngest;
    logic [`LSU_STORE_Q_DEPTH:0]   sq_count;
    logic [`LSU_STORE_Q_SIZE-1:0]  sq_addr_known;
    logic [31:0]                   sq_addr [`LSU_STORE_Q_SIZE];

    dmem_rd_if rd_bus ();

    assign issue = '{funct3: load_funct3_t'(issue_funct3), imm: issue_imm,
                     target_rob: issue_target_rob, rs1_ready: issue_rs1_ready,
                     rs1_rob: issue_rs1_rob, rs1_v: issue_rs1_v};

    always_comb begin
        for (int j = 0; j < `LSU_CDB_SIZE; j++) begin
            cdb[j] = '{valid: cdb_valid[j], rob: cdb_rob[j], value: cdb_value[j]};
        end
    end

    // unprivileged, secure, data access
    assign arprot = 3'b000;

    // rresp is not looked at, there is no error path for loads
    assign result_valid = result.valid;
    assign result_rob = result.rob;
    assign result_value = result.value;

    store_queue u_store_queue (
        .clk(clk), .rst_n(rst_n), .flush(flush),
        .alloc(store_alloc), .alloc_tag(store_tag),
        .resolve(store_resolve), .resolve_tag(store_resolve_tag),
        .resolve_addr(store_resolve_addr), .commit(store_commit),
        .youngest(sq_youngest), .count(sq_count),
        .addr_known(sq_addr_known), .addr(sq_addr)
    );

    load_rs u_load_rs (
        .clk(clk), .rst_n(rst_n), .flush(flush),
        .issue_valid(issue_valid), .issue(issue), .issue_ready(issue_ready),
        .cdb(cdb), .sq_youngest(sq_youngest), .sq_count(sq_count),
        .sq_addr_known(sq_addr_known), .sq_addr(sq_addr), .sq_commit(store_commit),
        .rd(rd_bus.station), .result(result)
    );

    dmem_read_fsm u_dmem_read_fsm (
        .clk(clk), .rst_n(rst_n), .flush(flush), .rd(rd_bus.engine),
        .arvalid(arvalid), .araddr(araddr), .arready(arready),
        .rvalid(rvalid), .rdata(rdata), .rready(rready)
    );

endmodule

`default_nettype wire

// ==== verif/load_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lsu_config.svh"

module load_unit_tb;
    import rv32i_pkg::*;

    localparam int ROB_W = `LSU_ROB_DEPTH;
    localparam int ROB_N = 1 << `LSU_ROB_DEPTH;

    logic                          clk;
    logic                          rst_n;
    logic                          flush;
    logic                          issue_valid;
    logic                          issue_ready;
    logic [2:0]                    issue_funct3;
    logic [31:0]                   issue_imm;
    logic [ROB_W-1:0]              issue_target_rob;
    logic                          issue_rs1_ready;
    logic [ROB_W-1:0]              issue_rs1_rob;
    logic [31:0]                   issue_rs1_v;
    logic                          cdb_valid [`LSU_CDB_SIZE];
    logic [ROB_W-1:0]              cdb_rob [`LSU_CDB_SIZE];
    logic [31:0]                   cdb_value [`LSU_CDB_SIZE];
    logic                          store_alloc;
    logic [`LSU_STORE_Q_DEPTH-1:0] store_tag;
    logic                          store_resolve;
    logic [`LSU_STORE_Q_DEPTH-1:0] store_resolve_tag;
    logic [31:0]                   store_resolve_addr;
    logic                          store_commit;
    logic                          arvalid;
    logic [31:0]                   araddr;
    logic [2:0]                    arprot;
    logic                          arready;
    logic                          rvalid;
    logic [31:0]                   rdata;
    logic [1:0]                    rresp;
    logic                          rready;
    logic                          result_valid;
    logic [ROB_W-1:0]              result_rob;
    logic [31:0]                   result_value;

    // memory image keyed by word address
    logic [31:0]                   mem [logic [29:0]];
    logic [ROB_N-1:0]              live;
    logic [31:0]                   exp_addr [ROB_N];
    logic [2:0]                    exp_f3 [ROB_N];
    logic [31:0]                   last_araddr;
    logic [31:0]                   rng;
    // tag the next store allocation should get
    logic [`LSU_STORE_Q_DEPTH-1:0] next_store_tag;
    int                            pending = 0;
    int                            errors = 0;
    int                            checks = 0;
    int                            tests = 0;
    int                            test_base = 0;
    int                            n_cmds = 0;
    string                         cmds [$];

    load_unit_top i_load_unit_top (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // words outside the image get a pattern of their address
    function automatic logic [31:0] mem_word(input logic [31:0] a);
        if (mem.exists(a[31:2])) begin
            return mem[a[31:2]];
        end
        return {a[31:2], 2'b00} ^ 32'h9e37_79b9;
    endfunction

    // pick the lane by the low address bits and extend per funct3
    function automatic logic [31:0] extend_load(input logic [31:0] w, input logic [31:0] a,
                                                input logic [2:0] f3);
        mem_word_u   mw;
        logic [7:0]  b;
        logic [15:0] h;
        mw = w;
        b = mw.bytes[a[1:0]];
        h = {mw.bytes[{a[1], 1'b1}], mw.bytes[{a[1], 1'b0}]};
        case (f3)
            lb:      return {{24{b[7]}}, b};
            lbu:     return {24'h0, b};
            lh:      return {{16{h[15]}}, h};
            lhu:     return {16'h0, h};
            default: return w;
        endcase
    endfunction

    task automatic check_result();
        logic [ROB_W-1:0] rob;
        logic [31:0]      want;
        rob = result_rob;
        checks++;
        assert (live[rob]) else begin
            $display("unexpected result for rob %0d with value %h", rob, result_value);
            errors++;
        end
        if (live[rob]) begin
            want = extend_load(mem_word(exp_addr[rob]), exp_addr[rob], exp_f3[rob]);
            checks += 2;
            assert (result_value == want) else begin
                $display("error: result_value for rob %0d is %h, expected %h",
                         rob, result_value, want);
                errors++;
            end
            assert (last_araddr == {exp_addr[rob][31:2], 2'b00}) else begin
                $display("error: araddr for rob %0d was %h, expected %h",
                         rob, last_araddr, {exp_addr[rob][31:2], 2'b00});
                errors++;
            end
            live[rob] = 1'b0;
            pending--;
        end
    endtask

    always @(negedge clk) begin
        if (rst_n && result_valid) begin
            check_result();
        end
    end

    // AXI4-Lite read slave with random handshake delays
    initial begin : axi_slave
        logic [31:0] held_addr;
        rng = 32'hd422_9a6f;
        arready = 1'b0;
        rvalid = 1'b0;
        rdata = '0;
        rresp = 2'b00;
        last_araddr = '0;
        forever begin
            next_cycle();
            if (arvalid) begin
                rng = xorshift(rng);
                repeat (rng[1:0]) next_cycle();
                arready = 1'b1;
                held_addr = araddr;
                last_araddr = araddr;
                @(negedge clk);
                checks++;
                assert (arprot == 3'b000) else begin
                    $display("error: arprot is %h, expected 0", arprot);
                    errors++;
                end
                next_cycle();
                arready = 1'b0;
                rng = xorshift(rng);
                repeat (rng[1:0]) next_cycle();
                rvalid = 1'b1;
                rdata = mem_word(held_addr);
                @(negedge clk);
                checks++;
                assert (rready) else begin
                    $display("error: rready is %h while rvalid is high, expected 1", rready);
                    errors++;
                end
                next_cycle();
                rvalid = 1'b0;
            end
        end
    end

    task automatic run_command(input string line);
        byte         cmd;
        string       name;
        logic [31:0] a0;
        logic [31:0] a1;
        logic [31:0] a2;
        logic [31:0] a3;
        logic [31:0] a4;
        logic [31:0] a5;
        logic [31:0] a6;
        cmd = line.getc(0);
        void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h %h %h",
                      a0, a1, a2, a3, a4, a5, a6));
        case (cmd)
            "m": mem[a0[31:2]] = a1;
            "i": begin
                live[a2[ROB_W-1:0]] = 1'b1;
                exp_addr[a2[ROB_W-1:0]] = a6;
                exp_f3[a2[ROB_W-1:0]] = a0[2:0];
                pending++;
                issue_funct3 = a0[2:0];
                issue_imm = a1;
                issue_target_rob = a2[ROB_W-1:0];
                issue_rs1_ready = a3[0];
                issue_rs1_rob = a4[ROB_W-1:0];
                issue_rs1_v = a5;
                issue_valid = 1'b1;
                @(negedge clk);
                while (!issue_ready) @(negedge clk);
                next_cycle();
                issue_valid = 1'b0;
            end
            "c": begin
                cdb_valid[a0[0]] = 1'b1;
                cdb_rob[a0[0]] = a1[ROB_W-1:0];
                cdb_value[a0[0]] = a2;
                next_cycle();
                cdb_valid[a0[0]] = 1'b0;
            end
            "a": begin
                store_alloc = 1'b1;
                @(negedge clk);
                checks++;
                assert (store_tag == next_store_tag) else begin
                    $display("error: store_tag is %h, expected %h", store_tag,
                             next_store_tag);
                    errors++;
                end
                next_store_tag = next_store_tag + 1'b1;
                next_cycle();
                store_alloc = 1'b0;
            end
            "r": begin
                store_resolve = 1'b1;
                store_resolve_tag = a0[`LSU_STORE_Q_DEPTH-1:0];
                store_resolve_addr = a1;
                next_cycle();
                store_resolve = 1'b0;
            end
            "k": begin
                store_commit = 1'b1;
                next_cycle();
                store_commit = 1'b0;
            end
            "f": begin
                // flushed loads must never report
                flush = 1'b1;
                live = '0;
                pending = 0;
                next_store_tag = '0;
                next_cycle();
                flush = 1'b0;
            end
            "w": repeat (a0) next_cycle();
            "z": repeat (a0) begin
                @(negedge clk);
                checks++;
                assert (!arvalid) else begin
                    $display("error: arvalid is %h while the load is held back, expected 0",
                             arvalid);
                    errors++;
                end
                next_cycle();
            end
            "u": begin
                @(negedge clk);
                checks++;
                assert (issue_ready == a0[0]) else begin
                    $display("error: issue_ready is %h, expected %h", issue_ready, a0[0]);
                    errors++;
                end
                next_cycle();
            end
            "t": begin
                name = line.substr(2, line.len() - 1);
                wait (pending == 0);
                next_cycle();
                tests++;
                $display("test %0d %s: %s", tests, name,
                         (errors == test_base) ? "ok" : "failed");
                test_base = errors;
            end
            default: begin
                $display("unknown command in the test data: %s", line);
                errors++;
            end
        endcase
    endtask

    initial begin : main
        int    fd;
        int    rc;
        string line;
        rst_n = 1'b0;
        flush = 1'b0;
        issue_valid = 1'b0;
        issue_funct3 = '0;
        issue_imm = '0;
        issue_target_rob = '0;
        issue_rs1_ready = 1'b0;
        issue_rs1_rob = '0;
        issue_rs1_v = '0;
        for (int j = 0; j < `LSU_CDB_SIZE; j++) begin
            cdb_valid[j] = 1'b0;
            cdb_rob[j] = '0;
            cdb_value[j] = '0;
        end
        store_alloc = 1'b0;
        store_resolve = 1'b0;
        store_resolve_tag = '0;
        store_resolve_addr = '0;
        store_commit = 1'b0;
        live = '0;
        next_store_tag = '0;
        fd = $fopen("verif/load_unit_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open verif/load_unit_testdata.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                rc = $fgets(line, fd);
                if (rc > 0 && line.getc(line.len() - 1) == "\n") begin
                    line = line.substr(0, line.len() - 2);
                end
                if (line.len() > 0 && line.getc(0) != "#") begin
                    cmds.push_back(line);
                end
            end
            $fclose(fd);
            n_cmds = cmds.size();
        end
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        foreach (cmds[k]) begin
            run_command(cmds[k]);
        end
        repeat (4) next_cycle();
        checks++;
        assert (pending == 0) else begin
            $display("%0d expected results never arrived", pending);
            errors++;
        end
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // budget of 300 cycles per command line
    initial begin : watchdog
        wait (n_cmds > 0);
        #(n_cmds * 300 * 4);
        $display("timeout: the run did not finish its %0d command lines in time", n_cmds);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== load_unit.f ====
+incdir+src
src/rv32i_pkg.sv
src/lsu_pkg.sv
src/dmem_rd_if.sv
src/store_queue.sv
src/load_rs.sv
src/dmem_read_fsm.sv
src/load_unit_top.sv
verif/load_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the load unit testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f load_unit.f --top-module load_unit_tb \
    -o load_unit_sim &&
./obj_dir/load_unit_sim | tee /dev/stderr | grep -q -x -F '** PASS **' &&
echo "load unit simulation passed" ||
{ echo "load unit simulation failed"; exit 1; }

// ==== verif/load_unit_testdata.txt ====
# m addr data | i funct3 imm rob rs1_ready rs1_rob rs1_v load_addr | c port rob value
# a | r tag addr | k | f | w n | z n (no AR) | u issue_ready | t name ; numbers in hex
m 00000100 8c7b2a91
m 00000104 f0e1d2c3
m 00000200 12345678
m 00000300 80017ffe
i 0 1 0 1 0 100 101
i 0 3 1 1 0 100 103
i 4 0 2 1 0 100 100
i 4 2 3 1 0 100 102
i 1 2 4 1 0 100 102
i 1 0 5 1 0 104 104
i 5 0 6 1 0 300 300
i 2 4 7 1 0 100 104
t extension
i 5 6 1 0 5 0 202
z 8
c 1 5 1fc
t cdb_wakeup
a
i 2 0 2 1 0 300 300
z 8
r 0 400
t older_store_other_word
k
a
r 1 100
i 0 3 3 1 0 100 103
a
z 8
k
t older_store_same_word
i 1 0 4 1 0 104 104
i 4 5 5 1 0 100 105
i 2 0 6 1 0 200 200
i 5 2 7 1 0 300 302
u 0
z 6
k
t full_station
u 1
i 2 0 3 1 0 300 300
a
i 2 0 0 1 0 100 100
w 2
f
u 1
w 8
i 0 2 1 1 0 104 106
t flush
